// ==== all.f ====
src/alu_pkg.sv
src/alu_regfile.sv
src/alu_dispatch.sv
src/alu_lane.sv
src/alu_wb_arbiter.sv
src/alu_exec_cluster.sv
sim/tb_alu_exec_cluster.sv

// ==== Bender.yml ====
package:
  name: alu_exec_cluster

sources:
  - files:
      - src/alu_pkg.sv
      - src/alu_regfile.sv
      - src/alu_dispatch.sv
      - src/alu_lane.sv
      - src/alu_wb_arbiter.sv
      - src/alu_exec_cluster.sv
  - target: simulation
    files:
      - sim/tb_alu_exec_cluster.sv

// ==== sim/tb_alu_exec_cluster.sv ====
/*
 * Testbench for the two-lane execute cluster.
 * Drives micro-ops through the issue port and checks every writeback against a model.
 */
module tb_alu_exec_cluster;
	import alu_pkg::*;

	logic CLK;
	logic rst_n;
	logic flush;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	logic bp_random;
	alu_uop_t in_uop;
	alu_wb_t out_wb;
	alu_wb_t got;

	// Architectural state as seen in program order at issue time.
	xlen_t model [NUM_REGS];
	xlen_t model_snap [NUM_REGS];
	alu_wb_t exp_wb [16];
	logic [15:0] pending;
	int accept_edge [16];
	int wb_edge [16];
	alu_tag_t next_tag;
	alu_tag_t last_tag;
	alu_tag_t flushed [3];
	int cyc;
	int n_issued;
	int n_wb;
	int n_flushed;
	int stall_cnt;
	logic [31:0] rng;
	logic [31:0] bp_rng;

	alu_exec_cluster alu_exec_cluster_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.in_valid(in_valid),
		.in_uop(in_uop),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_wb(out_wb),
		.out_ready(out_ready)
	);

	always #4 CLK = ~CLK;

	// ======================================================================
	// Helpers and reference model
	// ======================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic xlen_t rand64();
		logic [31:0] hi;
		hi = rand32();
		return {hi, rand32()};
	endfunction

	function automatic xlen_t sext_word(input xlen_t v);
		return {{32{v[31]}}, v[31:0]};
	endfunction

	// RV64I semantics, with the immediate as second operand whenever use_imm is set.
	function automatic xlen_t alu_ref(input alu_uop_t u, input xlen_t a, input xlen_t r2);
		xlen_t b;
		xlen_t r;
		logic [5:0] sh;
		logic signed [31:0] lo_s;
		logic signed [63:0] a_s;
		b = u.use_imm ? u.imm : r2;
		sh = u.is32w ? {1'b0, b[4:0]} : b[5:0];
		lo_s = a[31:0];
		a_s = a;
		case (u.fun)
			ALU_AUIPC: r = u.pc + u.imm;
			ALU_ADD: r = a + b;
			ALU_SUB: r = a - b;
			ALU_SLT: begin
				if (u.is_unsigned) begin
					r = xlen_t'(a < b);
				end else begin
					r = xlen_t'($signed(a) < $signed(b));
				end
			end
			ALU_XOR: r = a ^ b;
			ALU_OR: r = a | b;
			ALU_AND: r = a & b;
			ALU_SLL: r = a << sh;
			ALU_SRL: r = u.is32w ? xlen_t'(a[31:0] >> sh) : a >> sh;
			ALU_SRA: r = u.is32w ? xlen_t'(lo_s >>> sh) : xlen_t'(a_s >>> sh);
			default: r = '0;
		endcase
		// Logic ops and set-less-than have no word form.
		if (u.is32w && u.fun inside {ALU_AUIPC, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA}) begin
			r = sext_word(r);
		end
		return r;
	endfunction

	// Every flag combination is reached as i walks through 0..79.
	function automatic alu_uop_t random_uop(input int i);
		alu_uop_t u;
		logic [31:0] r;
		r = rand32();
		u = '0;
		u.fun = alu_fun_t'(i % 10);
		u.is32w = (i / 10) % 2;
		u.is_unsigned = (i / 20) % 2;
		u.use_imm = (i / 40) % 2;
		u.rs1 = r[4:0];
		u.rs2 = r[9:5];
		u.rd = r[14:10];
		u.pc = rand64();
		u.imm = rand64();
		return u;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_wb(input string name, input alu_wb_t exp, input alu_wb_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
			report_failure("writeback record mismatch");
		end
	endtask

	task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%h got 0x%h", name, exp, act);
			report_failure("writeback data mismatch");
		end
	endtask

	// Called and returning at 1 time unit after a rising edge.
	task automatic issue_uop(input alu_uop_t u);
		alu_wb_t e;
		n_issued++;
		while (pending[next_tag]) begin
			@(posedge CLK);
			#1;
		end
		u.tag = next_tag;
		last_tag = next_tag;
		next_tag++;
		in_uop = u;
		in_valid = 1'b1;
		@(negedge CLK);
		while (!in_ready) @(negedge CLK);
		e.rd = u.rd;
		e.tag = u.tag;
		e.data = alu_ref(u, model[u.rs1], model[u.rs2]);
		exp_wb[u.tag] = e;
		pending[u.tag] = 1'b1;
		accept_edge[u.tag] = cyc + 1;
		if (u.rd != '0) begin
			model[u.rd] = e.data;
		end
		@(posedge CLK);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (pending != '0) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// ======================================================================
	// Monitor, back-pressure and timeout
	// ======================================================================

	always @(negedge CLK) begin
		if (rst_n && in_valid && !in_ready && !out_ready) begin
			stall_cnt++;
		end
		if (rst_n && out_valid && out_ready) begin
			got = out_wb;
			if (!pending[got.tag]) begin
				report_failure($sformatf("tag %0d written back without a pending micro-op", got.tag));
			end
			check_data("out_wb.data", exp_wb[got.tag].data, got.data);
			check_wb("out_wb", exp_wb[got.tag], got);
			pending[got.tag] = 1'b0;
			wb_edge[got.tag] = cyc + 1;
			n_wb++;
		end
	end

	always @(posedge CLK) begin
		if (bp_random) begin
			#1;
			bp_rng = xorshift(bp_rng);
			out_ready = bp_rng[7];
		end
	end

	always @(posedge CLK) begin
		cyc <= cyc + 1;
		if (cyc > 40 * n_issued + 200) begin
			report_failure($sformatf("timeout at cycle %0d, pending tags 0x%h", cyc, pending));
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		alu_uop_t u;
		reg_idx_t prev;
		int mode;
		CLK = 1'b0;
		rst_n = 1'b0;
		flush = 1'b0;
		in_valid = 1'b0;
		in_uop = '0;
		out_ready = 1'b1;
		bp_random = 1'b0;
		pending = '0;
		next_tag = '0;
		cyc = 0;
		n_issued = 0;
		n_wb = 0;
		stall_cnt = 0;
		n_flushed = 0;
		rng = 32'he554_1cb9;
		bp_rng = xorshift(32'he554_1cb9 ^ 32'h5a5a_5a5a);
		for (int r = 0; r < NUM_REGS; r++) begin
			model[r] = '0;
		end
		repeat (8) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		// Load every register, odd ones through auipc and even ones through addi.
		for (int r = 1; r < NUM_REGS; r++) begin
			u = '0;
			u.rd = reg_idx_t'(r);
			u.imm = rand64();
			u.use_imm = 1'b1;
			u.fun = (r % 2) ? ALU_AUIPC : ALU_ADD;
			issue_uop(u);
		end

		for (int i = 0; i < 300; i++) begin
			issue_uop(random_uop(i));
		end

		// Chains through the previous rd, including writes to x0.
		prev = 5'd1;
		for (int i = 0; i < 40; i++) begin
			u = random_uop(int'(rand32() % 80));
			mode = int'(rand32() % 3);
			if (mode == 0) begin
				u.rs1 = prev;
			end else if (mode == 1) begin
				u.rd = prev;
			end else begin
				u.rd = '0;
			end
			if (u.rd != '0) begin
				prev = u.rd;
			end
			issue_uop(u);
		end
		u = '0;
		u.fun = ALU_ADD;
		u.rd = 5'd9;
		issue_uop(u);

		bp_random = 1'b1;
		for (int i = 0; i < 60; i++) begin
			issue_uop(random_uop(int'(rand32() % 80)));
		end
		bp_random = 1'b0;
		@(posedge CLK);
		#1;
		out_ready = 1'b0;
		stall_cnt = 0;
		fork
			begin
				for (int i = 0; i < 8; i++) begin
					issue_uop(random_uop(int'(rand32() % 80)));
				end
			end
			begin
				repeat (20) @(posedge CLK);
				#1;
				out_ready = 1'b1;
			end
		join
		if (stall_cnt == 0) begin
			report_failure("in_ready never dropped while writeback was stalled");
		end

		// Flush three independent micro-ops held behind a stalled writeback.
		wait_idle();
		model_snap = model;
		out_ready = 1'b0;
		for (int i = 0; i < 3; i++) begin
			u = random_uop(i + 1);
			u.rs1 = reg_idx_t'(i + 1);
			u.rs2 = reg_idx_t'(i + 4);
			u.rd = reg_idx_t'(20 + i);
			issue_uop(u);
			flushed[i] = last_tag;
		end
		flush = 1'b1;
		out_ready = 1'b1;
		@(negedge CLK);
		if (in_ready || out_valid) begin
			report_failure("cluster accepted or wrote back during flush");
		end
		@(posedge CLK);
		#1;
		flush = 1'b0;
		model = model_snap;
		for (int i = 0; i < 3; i++) begin
			pending[flushed[i]] = 1'b0;
		end
		n_flushed = 3;
		repeat (10) @(posedge CLK);
		#1;
		for (int i = 0; i < 3; i++) begin
			u = random_uop(10 + i);
			u.rs1 = reg_idx_t'(20 + i);
			u.rs2 = reg_idx_t'(22 - i);
			u.rd = reg_idx_t'(25 + i);
			issue_uop(u);
		end

		wait_idle();
		u = '0;
		u.fun = ALU_ADD;
		u.rs1 = 5'd3;
		u.rs2 = 5'd4;
		u.rd = 5'd7;
		issue_uop(u);
		wait_idle();
		if (wb_edge[last_tag] - accept_edge[last_tag] != 2) begin
			report_failure($sformatf("isolated micro-op took %0d cycles instead of 2",
				wb_edge[last_tag] - accept_edge[last_tag]));
		end

		if (n_wb != n_issued - n_flushed) begin
			report_failure($sformatf("%0d writebacks seen for %0d surviving micro-ops",
				n_wb, n_issued - n_flushed));
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== src/alu_exec_cluster.sv ====
/*
 * Two-lane integer execute cluster, top level.
 * Dispatch, register file, ALU lanes and the shared writeback arbiter.
 */
module alu_exec_cluster (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic in_valid,
	input  alu_pkg::alu_uop_t in_uop,
	output logic in_ready,
	output logic out_valid,
	output alu_pkg::alu_wb_t out_wb,
	input  logic out_ready
);
	import alu_pkg::*;

	reg_idx_t rf_raddr [NUM_RD_PORTS];
	xlen_t rf_rdata [NUM_RD_PORTS];
	logic reg_we;
	reg_idx_t reg_waddr;
	xlen_t reg_wdata;
	lane_sel_t lane_valid;
	lane_sel_t lane_ready;
	alu_issue_t lane_issue [NUM_LANES];
	lane_sel_t wb_req_valid;
	alu_wb_t wb_req [NUM_LANES];
	lane_sel_t wb_grant;

	// The writeback handshake is also the register file write.
	assign reg_we = out_valid && out_ready;
	assign reg_waddr = out_wb.rd;
	assign reg_wdata = out_wb.data;

	alu_regfile alu_regfile_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.raddr(rf_raddr),
		.rdata(rf_rdata),
		.we(reg_we),
		.waddr(reg_waddr),
		.wdata(reg_wdata)
	);

	alu_dispatch alu_dispatch_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.in_valid(in_valid),
		.in_uop(in_uop),
		.in_ready(in_ready),
		.rf_raddr(rf_raddr),
		.rf_rdata(rf_rdata),
		.lane_valid(lane_valid),
		.lane_issue(lane_issue),
		.lane_ready(lane_ready),
		.wb_fire(reg_we),
		.wb_rd(reg_waddr)
	);

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		alu_lane alu_lane_i (
			.CLK(CLK),
			.rst_n(rst_n),
			.flush(flush),
			.issue_valid(lane_valid[l]),
			.issue(lane_issue[l]),
			.issue_ready(lane_ready[l]),
			.req_valid(wb_req_valid[l]),
			.req(wb_req[l]),
			.grant(wb_grant[l])
		);
	end

	alu_wb_arbiter alu_wb_arbiter_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.req_valid(wb_req_valid),
		.req(wb_req),
		.grant(wb_grant),
		.out_valid(out_valid),
		.out_wb(out_wb),
		.out_ready(out_ready)
	);

endmodule

// ==== src/alu_wb_arbiter.sv ====
/*
 * Round-robin writeback arbiter.
 * Picks one requesting lane per cycle and drives it onto the shared writeback port.
 */
module alu_wb_arbiter (
	input  logic CLK,
	input  logic rst_n,
	input  alu_pkg::lane_sel_t req_valid,
	input  alu_pkg::alu_wb_t req [alu_pkg::NUM_LANES],
	output alu_pkg::lane_sel_t grant,
	output logic out_valid,
	output alu_pkg::alu_wb_t out_wb,
	input  logic out_ready
);
	import alu_pkg::*;

	lane_idx_t ptr;
	lane_idx_t win;
	lane_sel_t pick;

	// Search from the pointer upward; the loop runs backwards so the
	// nearest requester is the last one assigned.
	always_comb begin
		int idx;
		pick = '0;
		win = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			idx = (int'(ptr) + i) % NUM_LANES;
			if (req_valid[idx]) begin
				pick = '0;
				pick[idx] = 1'b1;
				win = lane_idx_t'(idx);
			end
		end
	end

	assign out_valid = req_valid != '0;
	assign out_wb = req[win];
	assign grant = out_ready ? pick : '0;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (out_valid && out_ready) begin
			ptr <= (int'(win) == NUM_LANES - 1) ? '0 : win + 1'b1;
		end
	end

	// A grant names exactly one lane, and only one that is asking.
	a_grant_ok: assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0(grant) && ((grant & ~req_valid) == '0));

endmodule

// ==== src/alu_lane.sv ====
/*
 * One RV64I ALU lane.
 * Computes the result of an issued micro-op and holds it until writeback.
 */
module alu_lane (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic issue_valid,
	input  alu_pkg::alu_issue_t issue,
	output logic issue_ready,
	output logic req_valid,
	output alu_pkg::alu_wb_t req,
	input  logic grant
);
	import alu_pkg::*;

	xlen_t op_b;
	xlen_t add_sum;
	xlen_t add_res;
	xlen_t slt_res;
	xlen_t sll_full;
	xlen_t sll_res;
	xlen_t sr_res;
	xlen_t result;
	logic lt;
	logic sr_fill;
	logic [5:0] shamt;
	logic signed [XLEN:0] sr_in;
	logic signed [XLEN:0] sr_full;
	logic held_valid;
	alu_wb_t held;
	logic take;

	function automatic xlen_t sext32(input xlen_t v);
		return {{(XLEN-32){v[31]}}, v[31:0]};
	endfunction

	// ======================================================================
	// Datapath
	// ======================================================================

	always_comb begin
		op_b = issue.use_imm ? issue.imm : issue.src2;

		// The W forms compute in 64 bits and sign-extend the low word.
		case (issue.fun)
			ALU_AUIPC: add_sum = issue.pc + issue.imm;
			ALU_SUB: add_sum = issue.src1 - op_b;
			default: add_sum = issue.src1 + op_b;
		endcase
		add_res = issue.is32w ? sext32(add_sum) : add_sum;

		if (issue.is_unsigned) begin
			lt = issue.src1 < op_b;
		end else begin
			lt = $signed(issue.src1) < $signed(op_b);
		end
		slt_res = {{(XLEN-1){1'b0}}, lt};

		// Bit 5 of the shift amount only counts for the 64-bit forms.
		shamt = {~issue.is32w & op_b[5], op_b[4:0]};
		sll_full = issue.src1 << shamt;
		sll_res = issue.is32w ? sext32(sll_full) : sll_full;

		// Right shifts run on a 65-bit value whose top bits carry the fill.
		sr_fill = (issue.fun == ALU_SRA) && (issue.is32w ? issue.src1[31] : issue.src1[63]);
		if (issue.is32w) begin
			sr_in = {{(XLEN-31){sr_fill}}, issue.src1[31:0]};
		end else begin
			sr_in = {sr_fill, issue.src1};
		end
		sr_full = sr_in >>> shamt;
		sr_res = issue.is32w ? sext32(sr_full[XLEN-1:0]) : sr_full[XLEN-1:0];

		case (issue.fun)
			ALU_AUIPC, ALU_ADD, ALU_SUB: result = add_res;
			ALU_SLT: result = slt_res;
			ALU_XOR: result = issue.src1 ^ op_b;
			ALU_OR: result = issue.src1 | op_b;
			ALU_AND: result = issue.src1 & op_b;
			ALU_SLL: result = sll_res;
			ALU_SRL, ALU_SRA: result = sr_res;
			default: result = '0;
		endcase
	end

	// ======================================================================
	// Output register
	// ======================================================================

	// A new micro-op may enter in the cycle the held result leaves.
	assign issue_ready = !held_valid || grant;
	assign take = issue_valid && issue_ready;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			held_valid <= 1'b0;
			held <= '0;
		end else begin
			if (flush) begin
				held_valid <= 1'b0;
			end else if (take) begin
				held_valid <= 1'b1;
			end else if (grant) begin
				held_valid <= 1'b0;
			end
			if (take) begin
				held <= '{rd: issue.rd, tag: issue.tag, data: result};
			end
		end
	end

	assign req_valid = held_valid && !flush;
	assign req = held;

	a_req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		req_valid && !grant |=> flush || (req_valid && $stable(req)));

endmodule

// ==== src/alu_dispatch.sv ====
/*
 * Dispatch stage of the execute cluster.
 * Checks the busy scoreboard, reads operands and fills one issue register per lane.
 */
module alu_dispatch (
	input  logic CLK,
	input  logic rst_n,
	input  logic flush,
	input  logic in_valid,
	input  alu_pkg::alu_uop_t in_uop,
	output logic in_ready,
	output alu_pkg::reg_idx_t rf_raddr [alu_pkg::NUM_RD_PORTS],
	input  alu_pkg::xlen_t rf_rdata [alu_pkg::NUM_RD_PORTS],
	output alu_pkg::lane_sel_t lane_valid,
	output alu_pkg::alu_issue_t lane_issue [alu_pkg::NUM_LANES],
	input  alu_pkg::lane_sel_t lane_ready,
	input  logic wb_fire,
	input  alu_pkg::reg_idx_t wb_rd
);
	import alu_pkg::*;

	logic [NUM_REGS-1:0] busy;
	logic [NUM_REGS-1:0] clr_mask;
	logic [NUM_REGS-1:0] set_mask;
	logic [NUM_REGS-1:0] busy_eff;
	logic running;
	logic hazard;
	logic accept;
	lane_sel_t iss_valid;
	lane_sel_t slot_free;
	lane_sel_t slot_sel;
	alu_issue_t iss_q [NUM_LANES];
	alu_issue_t cand [NUM_LANES];

	// ======================================================================
	// Scoreboard and issue handshake
	// ======================================================================

	// A writeback in this cycle already releases its register.
	assign clr_mask = wb_fire ? (NUM_REGS'(1) << wb_rd) : '0;
	assign set_mask = (accept && in_uop.rd != '0) ? (NUM_REGS'(1) << in_uop.rd) : '0;
	assign busy_eff = busy & ~clr_mask;

	assign hazard = busy_eff[in_uop.rs1] || busy_eff[in_uop.rs2] || busy_eff[in_uop.rd];
	assign slot_free = ~iss_valid | lane_ready;
	// Lowest free slot wins.
	assign slot_sel = slot_free & (~slot_free + 1'b1);

	assign in_ready = running && !flush && !hazard && (slot_free != '0);
	assign accept = in_valid && in_ready;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			busy <= '0;
		end else begin
			running <= 1'b1;
			busy <= flush ? '0 : ((busy & ~clr_mask) | set_mask);
		end
	end

	// ======================================================================
	// Operand read and issue registers
	// ======================================================================

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			rf_raddr[2*l] = in_uop.rs1;
			rf_raddr[2*l+1] = in_uop.rs2;
			cand[l] = '{fun: in_uop.fun, is32w: in_uop.is32w,
				is_unsigned: in_uop.is_unsigned, use_imm: in_uop.use_imm,
				rd: in_uop.rd, tag: in_uop.tag, pc: in_uop.pc, imm: in_uop.imm,
				src1: rf_rdata[2*l], src2: rf_rdata[2*l+1]};
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			iss_valid <= '0;
			for (int l = 0; l < NUM_LANES; l++) begin
				iss_q[l] <= '0;
			end
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (flush) begin
					iss_valid[l] <= 1'b0;
				end else if (accept && slot_sel[l]) begin
					iss_valid[l] <= 1'b1;
					iss_q[l] <= cand[l];
				end else if (lane_ready[l]) begin
					iss_valid[l] <= 1'b0;
				end
			end
		end
	end

	assign lane_valid = iss_valid;
	assign lane_issue = iss_q;

	// Write-after-write order depends on this check against the scoreboard.
	a_rd_not_busy: assert property (@(posedge CLK) disable iff (!rst_n)
		accept |-> !busy[in_uop.rd] || (wb_fire && wb_rd == in_uop.rd));

endmodule

// ==== src/alu_regfile.sv ====
/*
 * Architectural register file, 32 x 64 bits.
 * Four combinational read ports with write bypass and one write port.
 */
module alu_regfile (
	input  logic CLK,
	input  logic rst_n,
	input  alu_pkg::reg_idx_t raddr [alu_pkg::NUM_RD_PORTS],
	output alu_pkg::xlen_t rdata [alu_pkg::NUM_RD_PORTS],
	input  logic we,
	input  alu_pkg::reg_idx_t waddr,
	input  alu_pkg::xlen_t wdata
);
	import alu_pkg::*;

	xlen_t regs [NUM_REGS];

	// Entry 0 is never written, so x0 stays at its reset value of zero.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// A reader that waited on a busy register may be accepted in the same
	// cycle as the writeback, so the write data is forwarded here.
	always_comb begin
		for (int p = 0; p < NUM_RD_PORTS; p++) begin
			if (raddr[p] == '0) begin
				rdata[p] = '0;
			end else if (we && raddr[p] == waddr) begin
				rdata[p] = wdata;
			end else begin
				rdata[p] = regs[raddr[p]];
			end
		end
	end

endmodule

// ==== src/alu_pkg.sv ====
/*
 * Shared definitions of the two-lane integer execute cluster.
 * Widths, ALU operation codes and the micro-op, issue and writeback records.
 */
package alu_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	localparam int XLEN = 64;
	localparam int NUM_REGS = 32;
	localparam int NUM_LANES = 2;

	// Each lane issue register owns a pair of register file read ports.
	localparam int NUM_RD_PORTS = 2 * NUM_LANES;

	localparam int LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] alu_tag_t;
	typedef logic [NUM_LANES-1:0] lane_sel_t;
	typedef logic [LANE_IDX_W-1:0] lane_idx_t;

	// ======================================================================
	// Operations and records
	// ======================================================================

	typedef enum logic [3:0] {
		ALU_AUIPC,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_fun_t;

	// Micro-op as it arrives on the issue port, before operands are read.
	typedef struct packed {
		alu_fun_t fun;
		logic is32w;
		logic is_unsigned;
		logic use_imm;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		xlen_t pc;
		xlen_t imm;
		alu_tag_t tag;
	} alu_uop_t;

	// Micro-op handed to a lane, with both source values already read.
	typedef struct packed {
		alu_fun_t fun;
		logic is32w;
		logic is_unsigned;
		logic use_imm;
		reg_idx_t rd;
		alu_tag_t tag;
		xlen_t pc;
		xlen_t imm;
		xlen_t src1;
		xlen_t src2;
	} alu_issue_t;

	typedef struct packed {
		reg_idx_t rd;
		alu_tag_t tag;
		xlen_t data;
	} alu_wb_t;

endpackage
